// File: files.f
+incdir+source
source/rvCtrlPkg.sv
source/aluDecoder.sv
source/memDecoder.sv
source/flowDecoder.sv
source/controlDecoder.sv
source/decodeStage.sv
tb/clockGen.sv
tb/decodeStageTb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f files.f \
		--top-module decodeStageTb -o decodeStageSim

run: compile
	./obj_dir/decodeStageSim

clean:
	rm -rf obj_dir

// File: tb/decodeStageTb.sv
// Decode stage testbench with stimulus, reference decode, LFSR, checker and timeout
`include "rvCtrl_cfg.svh"

module decodeStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    // 10 reset, 192 directed, 500 random cycles and margin
    localparam int CYCLE_LIMIT = 1000;

    logic                    clk;
    logic                    reset;
    logic                    instrValid;
    logic [`INSTR_WIDTH-1:0] instr;
    logic                    ctrlValid;
    rvCtrlPkg::ctrlWord      ctrl;

    logic [15:0]             lfsrState;
    logic [6:0]              opTable [12];
    int                      cycleCount = 0;
    logic                    sampReset;
    logic                    sampValid;
    logic [`INSTR_WIDTH-1:0] sampInstr;
    rvCtrlPkg::ctrlWord      expCtrl = '0;

    clockGen u_clockGen (.clk (clk), .reset (reset));

    decodeStage u_decodeStage (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            val       = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected control word, built field by field
    function automatic rvCtrlPkg::ctrlWord refDecode(input logic [`INSTR_WIDTH-1:0] ins);
        rvCtrlPkg::ctrlWord w;
        rvCtrlPkg::opcodeE  op;
        logic [2:0]         f3;
        logic               b5;
        logic               shift;
        w     = '0;
        op    = rvCtrlPkg::opcodeE'(ins[`OPCODE_MSB:`OPCODE_LSB]);
        f3    = ins[`FUNCT3_MSB:`FUNCT3_LSB];
        b5    = ins[`FUNCT7B5_POS];
        shift = (f3 == 3'd1) || (f3 == 3'd5);
        w.regWrite = op inside {rvCtrlPkg::OP_REG, rvCtrlPkg::OP_IMM, rvCtrlPkg::OP_LOAD,
                                rvCtrlPkg::OP_LUI, rvCtrlPkg::OP_AUIPC, rvCtrlPkg::OP_JAL,
                                rvCtrlPkg::OP_JALR};
        w.memEn    = op inside {rvCtrlPkg::OP_LOAD, rvCtrlPkg::OP_STORE};
        w.memWrite = op == rvCtrlPkg::OP_STORE;
        // A store writes 2**funct3 bytes from lane 0
        if (w.memWrite && f3 < 3'd3) begin
            w.byteEn = `BYTE_LANES'((1 << (1 << f3)) - 1);
        end
        w.pcSrc = (op == rvCtrlPkg::OP_JALR)   ? rvCtrlPkg::JUMP_REG
                : (op == rvCtrlPkg::OP_JAL)    ? rvCtrlPkg::JUMP_PC
                : (op == rvCtrlPkg::OP_BRANCH) ? rvCtrlPkg::BRANCH_COND
                :                                rvCtrlPkg::PC_PLUS4;
        w.immSrc = (op == rvCtrlPkg::OP_IMM) ? (shift ? rvCtrlPkg::IMM_SHAMT : rvCtrlPkg::IMM_I)
                 : (op inside {rvCtrlPkg::OP_LOAD, rvCtrlPkg::OP_JALR}) ? rvCtrlPkg::IMM_I
                 : (op == rvCtrlPkg::OP_STORE)  ? rvCtrlPkg::IMM_S
                 : (op == rvCtrlPkg::OP_BRANCH) ? rvCtrlPkg::IMM_B
                 : (op inside {rvCtrlPkg::OP_LUI, rvCtrlPkg::OP_AUIPC}) ? rvCtrlPkg::IMM_U
                 : (op == rvCtrlPkg::OP_JAL)    ? rvCtrlPkg::IMM_J : rvCtrlPkg::IMM_NONE;
        w.updatedPcSrc = (op inside {rvCtrlPkg::OP_JAL, rvCtrlPkg::OP_JALR}) ? rvCtrlPkg::UPC_PLUS4
                       : (op inside {rvCtrlPkg::OP_AUIPC, rvCtrlPkg::OP_BRANCH})
                         ? rvCtrlPkg::UPC_PLUS_IMM : rvCtrlPkg::UPC_NONE;
        w.aluSrcB = (op inside {rvCtrlPkg::OP_REG, rvCtrlPkg::OP_BRANCH}) ? rvCtrlPkg::SRC_RS2
                  : (op inside {rvCtrlPkg::OP_IMM, rvCtrlPkg::OP_LOAD, rvCtrlPkg::OP_STORE,
                                rvCtrlPkg::OP_LUI, rvCtrlPkg::OP_JALR})
                    ? rvCtrlPkg::SRC_IMM : rvCtrlPkg::SRC_NONE;
        w.computeSrc = (op inside {rvCtrlPkg::OP_REG, rvCtrlPkg::OP_IMM, rvCtrlPkg::OP_LOAD,
                                   rvCtrlPkg::OP_STORE}) ? rvCtrlPkg::CMP_ALU
                     : (op == rvCtrlPkg::OP_LUI) ? rvCtrlPkg::CMP_OPB
                     : (op inside {rvCtrlPkg::OP_AUIPC, rvCtrlPkg::OP_JAL, rvCtrlPkg::OP_JALR})
                       ? rvCtrlPkg::CMP_UPDATED_PC : rvCtrlPkg::CMP_NONE;
        w.resultSrc = (op == rvCtrlPkg::OP_LOAD) ? rvCtrlPkg::RES_MEMORY
                    : (w.regWrite) ? rvCtrlPkg::RES_COMPUTE : rvCtrlPkg::RES_NONE;
        // Bit 30 turns add into SUB and shift right into SRA
        if (op inside {rvCtrlPkg::OP_REG, rvCtrlPkg::OP_IMM}) begin
            case (f3)
                3'd0:    w.aluOp = rvCtrlPkg::ADD;
                3'd1:    w.aluOp = rvCtrlPkg::SLL;
                3'd2:    w.aluOp = rvCtrlPkg::SLT;
                3'd3:    w.aluOp = rvCtrlPkg::SLTU;
                3'd4:    w.aluOp = rvCtrlPkg::XOR;
                3'd5:    w.aluOp = rvCtrlPkg::SRL;
                3'd6:    w.aluOp = rvCtrlPkg::OR;
                default: w.aluOp = rvCtrlPkg::AND;
            endcase
            if (op == rvCtrlPkg::OP_REG && b5) begin
                w.aluOp = (f3 == 3'd0) ? rvCtrlPkg::SUB
                        : (f3 == 3'd5) ? rvCtrlPkg::SRA : rvCtrlPkg::ALU_NONE;
            end
            if (op == rvCtrlPkg::OP_IMM && b5 && f3 == 3'd5) begin
                w.aluOp = rvCtrlPkg::SRA;
            end
        end else if (w.memEn) begin
            w.aluOp = rvCtrlPkg::ADD;
        end else if (op == rvCtrlPkg::OP_BRANCH) begin
            w.aluOp = rvCtrlPkg::SUB;
        end
        if (op == rvCtrlPkg::OP_BRANCH) begin
            case (f3)
                3'd0:    w.condSrc = rvCtrlPkg::BEQ;
                3'd1:    w.condSrc = rvCtrlPkg::BNE;
                3'd4:    w.condSrc = rvCtrlPkg::BLT;
                3'd5:    w.condSrc = rvCtrlPkg::BGE;
                3'd6:    w.condSrc = rvCtrlPkg::BLTU;
                3'd7:    w.condSrc = rvCtrlPkg::BGEU;
                default: w.condSrc = rvCtrlPkg::NO_BRANCH;
            endcase
        end
        if (op == rvCtrlPkg::OP_LOAD) begin
            case (f3)
                3'd0:    w.truncSrc = rvCtrlPkg::BYTE;
                3'd1:    w.truncSrc = rvCtrlPkg::HALF;
                3'd2:    w.truncSrc = rvCtrlPkg::WORD;
                3'd4:    w.truncSrc = rvCtrlPkg::BYTE_U;
                3'd5:    w.truncSrc = rvCtrlPkg::HALF_U;
                default: w.truncSrc = rvCtrlPkg::NO_TRUNC;
            endcase
        end
        return w;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] expV, input logic [31:0] actV);
        if (actV !== expV) begin
            $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expV, actV);
            $display("=== FAIL ===");
            $fatal(1, "Check of %s failed", name);
        end
    endtask

    task automatic sendInstr(input logic valid, input logic [`INSTR_WIDTH-1:0] word);
        instrValid = valid;
        instr      = word;
        @(posedge clk);
        #1;
    endtask

    // Inputs taken at the edge, outputs checked at the falling edge
    always begin
        @(posedge clk);
        sampReset = reset;
        sampValid = instrValid;
        sampInstr = instr;
        @(negedge clk);
        if (sampReset) begin
            expCtrl = '0;
        end else if (sampValid) begin
            expCtrl = refDecode(sampInstr);
        end
        checkVal("ctrlValid", 32'(!sampReset && sampValid), 32'(ctrlValid));
        checkVal("ctrl.regWrite", 32'(expCtrl.regWrite), 32'(ctrl.regWrite));
        checkVal("ctrl.memEn", 32'(expCtrl.memEn), 32'(ctrl.memEn));
        checkVal("ctrl.memWrite", 32'(expCtrl.memWrite), 32'(ctrl.memWrite));
        checkVal("ctrl.byteEn", 32'(expCtrl.byteEn), 32'(ctrl.byteEn));
        checkVal("ctrl.pcSrc", 32'(expCtrl.pcSrc), 32'(ctrl.pcSrc));
        checkVal("ctrl.condSrc", 32'(expCtrl.condSrc), 32'(ctrl.condSrc));
        checkVal("ctrl.immSrc", 32'(expCtrl.immSrc), 32'(ctrl.immSrc));
        checkVal("ctrl.updatedPcSrc", 32'(expCtrl.updatedPcSrc), 32'(ctrl.updatedPcSrc));
        checkVal("ctrl.aluSrcB", 32'(expCtrl.aluSrcB), 32'(ctrl.aluSrcB));
        checkVal("ctrl.aluOp", 32'(expCtrl.aluOp), 32'(ctrl.aluOp));
        checkVal("ctrl.computeSrc", 32'(expCtrl.computeSrc), 32'(ctrl.computeSrc));
        checkVal("ctrl.resultSrc", 32'(expCtrl.resultSrc), 32'(ctrl.resultSrc));
        checkVal("ctrl.truncSrc", 32'(expCtrl.truncSrc), 32'(ctrl.truncSrc));
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("=== FAIL ===");
            $fatal(1, "Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    initial begin
        logic [`INSTR_WIDTH-1:0] ins;
        int                      pick;
        lfsrState  = 16'd9;
        instrValid = 1'b0;
        instr      = '0;
        // Nine legal opcodes, then three unlisted ones
        opTable = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h63,
                    7'h00, 7'h0f, 7'h73};
        @(negedge reset);
        @(posedge clk);
        #1;
        // Every opcode against every funct3 and bit 30
        for (int o = 0; o < 12; o++) begin
            for (int k = 0; k < 16; k++) begin
                ins                                = randBits(32);
                ins[`OPCODE_MSB:`OPCODE_LSB]       = opTable[o];
                ins[`FUNCT3_MSB:`FUNCT3_LSB]       = 3'(k);
                ins[`FUNCT7B5_POS]                 = k[3];
                sendInstr(1'b1, ins);
            end
        end
        // Random stream, about one idle cycle in four
        repeat (500) begin
            ins                          = randBits(32);
            pick                         = int'(randBits(4)) % 12;
            ins[`OPCODE_MSB:`OPCODE_LSB] = opTable[pick];
            sendInstr(randBits(2) != 0, ins);
        end
        sendInstr(1'b0, '0);
        repeat (2) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb/clockGen.sv
// Testbench clock and synchronous reset generator
module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Held for 10 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: source/decodeStage.sv
// Decode stage top with the control decoder and the registered control word
`include "rvCtrl_cfg.svh"

module decodeStage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instrValid,
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic                    ctrlValid,
    output rvCtrlPkg::ctrlWord      ctrl
);

    rvCtrlPkg::ctrlWord nextCtrl;

    controlDecoder u_controlDecoder (
        .instr (instr),
        .ctrl  (nextCtrl)
    );

    // Word holds across idle cycles, valid drops
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrl <= nextCtrl;
            end
        end
    end

    // Execute stage must see a quiet no-op word out of reset
    assert property (@(posedge clk) reset |=> (!ctrlValid && ctrl == '0))
        else $error("decode stage not cleared on the cycle after reset");

endmodule

// File: source/controlDecoder.sv
// Instruction field split and opcode selection among the class control words
`include "rvCtrl_cfg.svh"

module controlDecoder (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output rvCtrlPkg::ctrlWord      ctrl
);

    rvCtrlPkg::opcodeE                      opcode;
    logic [`FUNCT3_MSB-`FUNCT3_LSB:0]       funct3;
    logic                                   funct7b5;

    rvCtrlPkg::ctrlWord regCtrl;
    rvCtrlPkg::ctrlWord immCtrl;
    rvCtrlPkg::ctrlWord loadCtrl;
    rvCtrlPkg::ctrlWord storeCtrl;
    rvCtrlPkg::ctrlWord luiCtrl;
    rvCtrlPkg::ctrlWord auipcCtrl;
    rvCtrlPkg::ctrlWord jalCtrl;
    rvCtrlPkg::ctrlWord jalrCtrl;
    rvCtrlPkg::ctrlWord branchCtrl;

    assign opcode   = rvCtrlPkg::opcodeE'(instr[`OPCODE_MSB:`OPCODE_LSB]);
    assign funct3   = instr[`FUNCT3_MSB:`FUNCT3_LSB];
    assign funct7b5 = instr[`FUNCT7B5_POS];

    aluDecoder u_aluDecoder (
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .regCtrl  (regCtrl),
        .immCtrl  (immCtrl)
    );

    memDecoder u_memDecoder (
        .funct3    (funct3),
        .loadCtrl  (loadCtrl),
        .storeCtrl (storeCtrl)
    );

    flowDecoder u_flowDecoder (
        .funct3     (funct3),
        .luiCtrl    (luiCtrl),
        .auipcCtrl  (auipcCtrl),
        .jalCtrl    (jalCtrl),
        .jalrCtrl   (jalrCtrl),
        .branchCtrl (branchCtrl)
    );

    // Unknown opcode falls through to the no-op word
    always_comb begin
        case (opcode)
            rvCtrlPkg::OP_REG:    ctrl = regCtrl;
            rvCtrlPkg::OP_IMM:    ctrl = immCtrl;
            rvCtrlPkg::OP_LOAD:   ctrl = loadCtrl;
            rvCtrlPkg::OP_STORE:  ctrl = storeCtrl;
            rvCtrlPkg::OP_LUI:    ctrl = luiCtrl;
            rvCtrlPkg::OP_AUIPC:  ctrl = auipcCtrl;
            rvCtrlPkg::OP_JAL:    ctrl = jalCtrl;
            rvCtrlPkg::OP_JALR:   ctrl = jalrCtrl;
            rvCtrlPkg::OP_BRANCH: ctrl = branchCtrl;
            default:              ctrl = '0;
        endcase
    end

    // A write strobe without the memory enable would be dropped by the LSU
    always_comb begin
        assert final (!ctrl.memWrite || ctrl.memEn)
            else $error("memWrite without memEn for opcode %b", opcode);
    end

endmodule

// File: source/flowDecoder.sv
// Control words for LUI, AUIPC, JAL, JALR and conditional branches
module flowDecoder (
    input  logic [2:0]         funct3,
    output rvCtrlPkg::ctrlWord luiCtrl,
    output rvCtrlPkg::ctrlWord auipcCtrl,
    output rvCtrlPkg::ctrlWord jalCtrl,
    output rvCtrlPkg::ctrlWord jalrCtrl,
    output rvCtrlPkg::ctrlWord branchCtrl
);

    // Upper immediate, LUI passes operand B straight through
    always_comb begin
        luiCtrl            = '0;
        luiCtrl.regWrite   = 1'b1;
        luiCtrl.pcSrc      = rvCtrlPkg::PC_PLUS4;
        luiCtrl.immSrc     = rvCtrlPkg::IMM_U;
        luiCtrl.aluSrcB    = rvCtrlPkg::SRC_IMM;
        luiCtrl.computeSrc = rvCtrlPkg::CMP_OPB;
        luiCtrl.resultSrc  = rvCtrlPkg::RES_COMPUTE;

        // AUIPC writes PC plus immediate
        auipcCtrl              = '0;
        auipcCtrl.regWrite     = 1'b1;
        auipcCtrl.pcSrc        = rvCtrlPkg::PC_PLUS4;
        auipcCtrl.immSrc       = rvCtrlPkg::IMM_U;
        auipcCtrl.updatedPcSrc = rvCtrlPkg::UPC_PLUS_IMM;
        auipcCtrl.computeSrc   = rvCtrlPkg::CMP_UPDATED_PC;
        auipcCtrl.resultSrc    = rvCtrlPkg::RES_COMPUTE;
    end

    // Jumps link PC+4 into rd
    always_comb begin
        jalCtrl              = '0;
        jalCtrl.regWrite     = 1'b1;
        jalCtrl.pcSrc        = rvCtrlPkg::JUMP_PC;
        jalCtrl.immSrc       = rvCtrlPkg::IMM_J;
        jalCtrl.updatedPcSrc = rvCtrlPkg::UPC_PLUS4;
        jalCtrl.computeSrc   = rvCtrlPkg::CMP_UPDATED_PC;
        jalCtrl.resultSrc    = rvCtrlPkg::RES_COMPUTE;

        // JALR target comes from rs1 plus the I immediate
        jalrCtrl         = jalCtrl;
        jalrCtrl.pcSrc   = rvCtrlPkg::JUMP_REG;
        jalrCtrl.immSrc  = rvCtrlPkg::IMM_I;
        jalrCtrl.aluSrcB = rvCtrlPkg::SRC_IMM;
    end

    // Compare is rs1 minus rs2, target is PC plus the B immediate
    always_comb begin
        branchCtrl              = '0;
        branchCtrl.pcSrc        = rvCtrlPkg::BRANCH_COND;
        branchCtrl.immSrc       = rvCtrlPkg::IMM_B;
        branchCtrl.updatedPcSrc = rvCtrlPkg::UPC_PLUS_IMM;
        branchCtrl.aluSrcB      = rvCtrlPkg::SRC_RS2;
        branchCtrl.aluOp        = rvCtrlPkg::SUB;
        case (funct3)
            3'b000:  branchCtrl.condSrc = rvCtrlPkg::BEQ;
            3'b001:  branchCtrl.condSrc = rvCtrlPkg::BNE;
            3'b100:  branchCtrl.condSrc = rvCtrlPkg::BLT;
            3'b101:  branchCtrl.condSrc = rvCtrlPkg::BGE;
            3'b110:  branchCtrl.condSrc = rvCtrlPkg::BLTU;
            3'b111:  branchCtrl.condSrc = rvCtrlPkg::BGEU;
            // funct3 2 and 3 are not branches
            default: branchCtrl.condSrc = rvCtrlPkg::NO_BRANCH;
        endcase
    end

endmodule

// File: source/memDecoder.sv
// Control words for load and store instructions
`include "rvCtrl_cfg.svh"

module memDecoder (
    input  logic [2:0]         funct3,
    output rvCtrlPkg::ctrlWord loadCtrl,
    output rvCtrlPkg::ctrlWord storeCtrl
);

    // Address is rs1 plus the I-type immediate
    always_comb begin
        loadCtrl            = '0;
        loadCtrl.regWrite   = 1'b1;
        loadCtrl.memEn      = 1'b1;
        loadCtrl.pcSrc      = rvCtrlPkg::PC_PLUS4;
        loadCtrl.immSrc     = rvCtrlPkg::IMM_I;
        loadCtrl.aluSrcB    = rvCtrlPkg::SRC_IMM;
        loadCtrl.aluOp      = rvCtrlPkg::ADD;
        loadCtrl.computeSrc = rvCtrlPkg::CMP_ALU;
        loadCtrl.resultSrc  = rvCtrlPkg::RES_MEMORY;
        case (funct3)
            3'b000:  loadCtrl.truncSrc = rvCtrlPkg::BYTE;
            3'b001:  loadCtrl.truncSrc = rvCtrlPkg::HALF;
            3'b010:  loadCtrl.truncSrc = rvCtrlPkg::WORD;
            3'b100:  loadCtrl.truncSrc = rvCtrlPkg::BYTE_U;
            3'b101:  loadCtrl.truncSrc = rvCtrlPkg::HALF_U;
            default: loadCtrl.truncSrc = rvCtrlPkg::NO_TRUNC;
        endcase
    end

    // Address is rs1 plus the S-type immediate, no writeback
    always_comb begin
        storeCtrl            = '0;
        storeCtrl.memEn      = 1'b1;
        storeCtrl.memWrite   = 1'b1;
        storeCtrl.pcSrc      = rvCtrlPkg::PC_PLUS4;
        storeCtrl.immSrc     = rvCtrlPkg::IMM_S;
        storeCtrl.aluSrcB    = rvCtrlPkg::SRC_IMM;
        storeCtrl.aluOp      = rvCtrlPkg::ADD;
        storeCtrl.computeSrc = rvCtrlPkg::CMP_ALU;
        case (funct3)
            3'b000:  storeCtrl.byteEn = `BYTE_LANES'(1);
            3'b001:  storeCtrl.byteEn = `BYTE_LANES'(3);
            3'b010:  storeCtrl.byteEn = '1;
            default: storeCtrl.byteEn = '0;
        endcase
    end

    // Lanes must run unbroken from lane 0 or the write data is misaligned
    always_comb begin
        assert final (!storeCtrl.memWrite || storeCtrl.byteEn == '0
                      || (storeCtrl.byteEn & (storeCtrl.byteEn + `BYTE_LANES'(1))) == '0)
            else $error("store byte enable %b not contiguous from lane 0", storeCtrl.byteEn);
    end

endmodule

// File: source/aluDecoder.sv
// Control words for register-register and register-immediate ALU instructions
module aluDecoder (
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    output rvCtrlPkg::ctrlWord regCtrl,
    output rvCtrlPkg::ctrlWord immCtrl
);

    // Register form, funct7 bit 5 only legal on add and right shift
    always_comb begin
        regCtrl            = '0;
        regCtrl.regWrite   = 1'b1;
        regCtrl.pcSrc      = rvCtrlPkg::PC_PLUS4;
        regCtrl.aluSrcB    = rvCtrlPkg::SRC_RS2;
        regCtrl.computeSrc = rvCtrlPkg::CMP_ALU;
        regCtrl.resultSrc  = rvCtrlPkg::RES_COMPUTE;
        case ({funct7b5, funct3})
            4'b0_000: regCtrl.aluOp = rvCtrlPkg::ADD;
            4'b1_000: regCtrl.aluOp = rvCtrlPkg::SUB;
            4'b0_001: regCtrl.aluOp = rvCtrlPkg::SLL;
            4'b0_010: regCtrl.aluOp = rvCtrlPkg::SLT;
            4'b0_011: regCtrl.aluOp = rvCtrlPkg::SLTU;
            4'b0_100: regCtrl.aluOp = rvCtrlPkg::XOR;
            4'b0_101: regCtrl.aluOp = rvCtrlPkg::SRL;
            4'b1_101: regCtrl.aluOp = rvCtrlPkg::SRA;
            4'b0_110: regCtrl.aluOp = rvCtrlPkg::OR;
            4'b0_111: regCtrl.aluOp = rvCtrlPkg::AND;
            default:  regCtrl.aluOp = rvCtrlPkg::ALU_NONE;
        endcase
    end

    // Immediate form, no subtract since the immediate can be negative
    always_comb begin
        immCtrl            = '0;
        immCtrl.regWrite   = 1'b1;
        immCtrl.pcSrc      = rvCtrlPkg::PC_PLUS4;
        immCtrl.aluSrcB    = rvCtrlPkg::SRC_IMM;
        immCtrl.immSrc     = rvCtrlPkg::IMM_I;
        immCtrl.computeSrc = rvCtrlPkg::CMP_ALU;
        immCtrl.resultSrc  = rvCtrlPkg::RES_COMPUTE;
        case (funct3)
            3'b000: immCtrl.aluOp = rvCtrlPkg::ADD;
            3'b010: immCtrl.aluOp = rvCtrlPkg::SLT;
            3'b011: immCtrl.aluOp = rvCtrlPkg::SLTU;
            3'b100: immCtrl.aluOp = rvCtrlPkg::XOR;
            3'b110: immCtrl.aluOp = rvCtrlPkg::OR;
            3'b111: immCtrl.aluOp = rvCtrlPkg::AND;
            3'b001: begin
                immCtrl.immSrc = rvCtrlPkg::IMM_SHAMT;
                immCtrl.aluOp  = rvCtrlPkg::SLL;
            end
            default: begin
                // Shift right, arithmetic when bit 30 is set
                immCtrl.immSrc = rvCtrlPkg::IMM_SHAMT;
                immCtrl.aluOp  = funct7b5 ? rvCtrlPkg::SRA : rvCtrlPkg::SRL;
            end
        endcase
    end

    always_comb begin
        assert final (immCtrl.aluOp != rvCtrlPkg::SUB)
            else $error("immediate ALU word decoded as SUB, funct3 %b", funct3);
    end

endmodule

// File: source/rvCtrlPkg.sv
// Opcode enum, datapath select enums and the packed control word
`include "rvCtrl_cfg.svh"

package rvCtrlPkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeE;

    // Next PC source
    typedef enum logic [1:0] {
        PC_PLUS4,
        JUMP_REG,
        JUMP_PC,
        BRANCH_COND
    } pcSrcE;

    typedef enum logic [2:0] {
        NO_BRANCH,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } condSrcE;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immSrcE;

    typedef enum logic [1:0] {
        UPC_NONE,
        UPC_PLUS4,
        UPC_PLUS_IMM
    } updatedPcSrcE;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_RS2,
        SRC_IMM
    } aluSrcBE;

    typedef enum logic [3:0] {
        ALU_NONE,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU
    } aluOpE;

    // Value handed to the result mux
    typedef enum logic [1:0] {
        CMP_NONE,
        CMP_ALU,
        CMP_OPB,
        CMP_UPDATED_PC
    } computeSrcE;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_COMPUTE,
        RES_MEMORY
    } resultSrcE;

    // Load data extension
    typedef enum logic [2:0] {
        NO_TRUNC,
        BYTE,
        HALF,
        WORD,
        BYTE_U,
        HALF_U
    } truncSrcE;

    // All zero is the no-op word
    typedef struct packed {
        logic                     regWrite;
        logic                     memEn;
        logic                     memWrite;
        logic [`BYTE_LANES-1:0]   byteEn;
        pcSrcE                    pcSrc;
        condSrcE                  condSrc;
        immSrcE                   immSrc;
        updatedPcSrcE             updatedPcSrc;
        aluSrcBE                  aluSrcB;
        aluOpE                    aluOp;
        computeSrcE               computeSrc;
        resultSrcE                resultSrc;
        truncSrcE                 truncSrc;
    } ctrlWord;

endpackage

// File: source/rvCtrl_cfg.svh
// Instruction width, store byte lanes and instruction field positions
`ifndef RV_CTRL_CFG_SVH
`define RV_CTRL_CFG_SVH

// RV32I base instruction width
`define INSTR_WIDTH 32

// Store byte enable, fixed at a 32-bit data bus
`define BYTE_LANES 4

// Major opcode
`define OPCODE_LSB 0
`define OPCODE_MSB 6

// Minor opcode
`define FUNCT3_LSB 12
`define FUNCT3_MSB 14

// Picks SUB over ADD and SRA over SRL
`define FUNCT7B5_POS 30

`endif
